// File: list.f
rtl/sf_pkg.sv
rtl/sf_param_mem.sv
rtl/sf_sequencer.sv
rtl/sf_datapath.sv
rtl/sf_trace.sv
rtl/sf_top.sv
tb/sf_tb.sv

// File: rtl/sf_datapath.sv
// Single-stage update on F3; products floor toward minus infinity, every clamp raises sat_hit
`timescale 1ns/10ps
`default_nettype none

module sf_datapath (
        input  wire                    clk,
        input  wire                    rst_n_i,
        input  wire                    ce_i,
        input  wire sf_pkg::fetch_step_e step_i,
        input  wire sf_pkg::sample_t   rd_data_i,
        input  wire sf_pkg::sample_t   meas_i,
        output sf_pkg::sf_out_t        result_o,
        output sf_pkg::acc_t           integ_o,
        output logic                   upd_o,
        output logic                   sat_hit_o
);
        import sf_pkg::*;

        // Wide enough for any product or sum below
        localparam int WW = 2 * SF_PW + 4;
        typedef logic signed [WW-1:0] wide_t;

        sample_t k_p_q, k_i_q, k_g_q;
        wide_t   s_a, s_i, s_c, s_d;
        acc_t    i_n;
        sample_t a_n, b_n, c_n, d_n;
        logic    hit;

        // ----------------------------------------------------------------------
        // Arithmetic helpers
        // ----------------------------------------------------------------------

        function automatic wide_t prod(input sample_t x, input sample_t k);
                wide_t p;
                p = x * k;
                return p >>> SF_FRAC;
        endfunction

        // True when v does not fit in w signed bits
        function automatic logic ovf(input wide_t v, input int w);
                wide_t t;
                t = v >>> (w - 1);
                return (t != '0) && (t != '1);
        endfunction

        function automatic sample_t sat_pw(input wide_t v);
                if (!ovf(v, SF_PW))
                        return v[SF_PW-1:0];
                return v[WW-1] ? {1'b1, {(SF_PW-1){1'b0}}} : {1'b0, {(SF_PW-1){1'b1}}};
        endfunction

        function automatic acc_t sat_tw(input wide_t v);
                if (!ovf(v, SF_TW))
                        return v[SF_TW-1:0];
                return v[WW-1] ? {1'b1, {(SF_TW-1){1'b0}}} : {1'b0, {(SF_TW-1){1'b1}}};
        endfunction

        // ----------------------------------------------------------------------
        // Coefficient capture
        // ----------------------------------------------------------------------

        // K_OFS is used straight off the read data during F3
        always_ff @(posedge clk) begin
                if (ce_i) begin
                        case (step_i)
                                F0: k_p_q <= rd_data_i;
                                F1: k_i_q <= rd_data_i;
                                F2: k_g_q <= rd_data_i;
                                default: ;
                        endcase
                end
        end

        // ----------------------------------------------------------------------
        // Update equations
        // ----------------------------------------------------------------------

        always_comb begin
                s_a = prod(meas_i, k_p_q);
                a_n = sat_pw(s_a);
                s_i = integ_o + prod(meas_i, k_i_q);
                i_n = sat_tw(s_i);
                b_n = sat_pw(i_n);
                s_c = a_n + b_n;
                c_n = sat_pw(s_c);
                s_d = prod(c_n, k_g_q) + rd_data_i;
                d_n = sat_pw(s_d);
                hit = ovf(s_a, SF_PW) | ovf(s_i, SF_TW) | ovf(i_n, SF_PW)
                        | ovf(s_c, SF_PW) | ovf(s_d, SF_PW);
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        result_o  <= '0;
                        integ_o   <= '0;
                        upd_o     <= 1'b0;
                        sat_hit_o <= 1'b0;
                end else if (ce_i) begin
                        upd_o <= (step_i == F3);
                        if (step_i == F3) begin
                                result_o  <= '{a_n, b_n, c_n, d_n};
                                integ_o   <= i_n;
                                sat_hit_o <= hit;
                        end
                end
        end

endmodule

`default_nettype wire

// File: rtl/sf_param_mem.sv
// Four-entry coefficient store; read data lags the address by one ce cycle, read-during-write gives old data
`timescale 1ns/10ps
`default_nettype none

module sf_param_mem (
        input  wire                      clk,
        input  wire                      rst_n_i,
        input  wire                      ce_i,
        input  wire                      h_write_i,
        input  wire [sf_pkg::SF_CAW-1:0] h_addr_i,
        input  wire sf_pkg::sample_t     h_data_i,
        input  wire sf_pkg::coef_idx_e   rd_addr_i,
        output sf_pkg::sample_t          rd_data_o
);
        import sf_pkg::*;

        sample_t mem_q [2**SF_CAW];

        // Host port
        always_ff @(posedge clk) begin
                if (ce_i && h_write_i)
                        mem_q[h_addr_i] <= h_data_i;
        end

        // Sequencer port, registered
        always_ff @(posedge clk) begin
                if (ce_i)
                        rd_data_o <= mem_q[rd_addr_i];
        end

        // ----------------------------------------------------------------------
        // Checks
        // ----------------------------------------------------------------------

        // The sequencer must present a clean address on every enabled cycle
        a_rd_addr_known: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                ce_i |-> !$isunknown(rd_addr_i)
        );

endmodule

`default_nettype wire

// File: rtl/sf_pkg.sv
// Shared Q1.17 types; word counts are fixed by the update equations and widths are not tunable
`default_nettype none

package sf_pkg;

        // ----------------------------------------------------------------------
        // Widths
        // ----------------------------------------------------------------------

        // Samples and coefficients in Q1.17
        localparam int SF_PW   = 18;
        // Integrator and trace words carry four bits of headroom
        localparam int SF_TW   = SF_PW + 4;
        localparam int SF_FRAC = SF_PW - 1;
        localparam int SF_CAW  = 2;

        typedef logic signed [SF_PW-1:0] sample_t;
        typedef logic signed [SF_TW-1:0] acc_t;

        // ----------------------------------------------------------------------
        // Coefficient map and fetch sequence
        // ----------------------------------------------------------------------

        typedef enum logic [SF_CAW-1:0] {
                K_P   = 2'd0,
                K_I   = 2'd1,
                K_G   = 2'd2,
                K_OFS = 2'd3
        } coef_idx_e;

        // Names the coefficient present on the memory read data
        typedef enum logic [2:0] {
                IDLE,
                F0,
                F1,
                F2,
                F3
        } fetch_step_e;

        // ----------------------------------------------------------------------
        // Results and trace
        // ----------------------------------------------------------------------

        typedef struct packed {
                sample_t a;
                sample_t b;
                sample_t c;
                sample_t d;
        } sf_out_t;

        // Address width is a module parameter, so it travels on its own port
        typedef struct packed {
                acc_t data;
        } sf_trace_t;

endpackage

`default_nettype wire

// File: rtl/sf_sequencer.sv
// Triggers while busy are dropped; busy holds until the trace block reports its last word
`timescale 1ns/10ps
`default_nettype none

module sf_sequencer (
        input  wire                    clk,
        input  wire                    rst_n_i,
        input  wire                    ce_i,
        input  wire                    trigger_i,
        input  wire sf_pkg::sample_t   meas_i,
        output sf_pkg::coef_idx_e      rd_addr_o,
        output sf_pkg::fetch_step_e    step_o,
        output sf_pkg::sample_t        meas_o,
        output logic                   busy_o,
        input  wire                    trace_done_i
);
        import sf_pkg::*;

        typedef enum logic [1:0] {
                S_IDLE,
                S_FETCH,
                S_WAIT
        } state_e;

        state_e state_q;

        assign busy_o = (state_q != S_IDLE);

        // ----------------------------------------------------------------------
        // FSM
        // ----------------------------------------------------------------------

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q   <= S_IDLE;
                        rd_addr_o <= K_P;
                        step_o    <= IDLE;
                end else if (ce_i) begin
                        step_o <= IDLE;
                        case (state_q)
                                S_IDLE: begin
                                        if (trigger_i)
                                                state_q <= S_FETCH;
                                end
                                S_FETCH: begin
                                        // Step trails the address so it lines up with read data
                                        step_o    <= fetch_step_e'(3'(rd_addr_o) + 3'd1);
                                        rd_addr_o <= coef_idx_e'(rd_addr_o + 1'b1);
                                        if (rd_addr_o == K_OFS)
                                                state_q <= S_WAIT;
                                end
                                S_WAIT: begin
                                        if (trace_done_i)
                                                state_q <= S_IDLE;
                                end
                                default: state_q <= S_IDLE;
                        endcase
                end
        end

        // Sample is held for the whole update and trace
        always_ff @(posedge clk) begin
                if (ce_i && state_q == S_IDLE && trigger_i)
                        meas_o <= meas_i;
        end

        // ----------------------------------------------------------------------
        // Checks
        // ----------------------------------------------------------------------

        a_step_busy: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                !$stable(step_o) |-> busy_o
        );

endmodule

`default_nettype wire

// File: rtl/sf_top.sv
// Host writes coefficients while idle; result_o holds the last update until the next trigger completes
`timescale 1ns/10ps
`default_nettype none

module sf_top #(
        parameter int trace_aw = 7,
        parameter int sat_w    = 7
) (
        input  wire                      clk,
        input  wire                      rst_n_i,
        input  wire                      ce_i,
        input  wire sf_pkg::sample_t     meas_i,
        input  wire                      trigger_i,
        input  wire                      h_write_i,
        input  wire [sf_pkg::SF_CAW-1:0] h_addr_i,
        input  wire sf_pkg::sample_t     h_data_i,
        output sf_pkg::sf_out_t          result_o,
        output logic                     busy_o,
        output sf_pkg::sf_trace_t        trace_o,
        output logic [trace_aw-1:0]      trace_addr_o,
        output logic                     trace_strobe_o,
        output logic [sat_w-1:0]         sat_count_o
);
        import sf_pkg::*;

        coef_idx_e   rd_addr;
        sample_t     rd_data;
        sample_t     meas_q;
        fetch_step_e step;
        acc_t        integ;
        logic        upd;
        logic        sat_hit;
        logic        trace_done;

        // Coefficient store
        sf_param_mem u_mem (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .ce_i      (ce_i),
                .h_write_i (h_write_i),
                .h_addr_i  (h_addr_i),
                .h_data_i  (h_data_i),
                .rd_addr_i (rd_addr),
                .rd_data_o (rd_data)
        );

        sf_sequencer u_seq (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .ce_i         (ce_i),
                .trigger_i    (trigger_i),
                .meas_i       (meas_i),
                .rd_addr_o    (rd_addr),
                .step_o       (step),
                .meas_o       (meas_q),
                .busy_o       (busy_o),
                .trace_done_i (trace_done)
        );

        sf_datapath u_dp (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .ce_i      (ce_i),
                .step_i    (step),
                .rd_data_i (rd_data),
                .meas_i    (meas_q),
                .result_o  (result_o),
                .integ_o   (integ),
                .upd_o     (upd),
                .sat_hit_o (sat_hit)
        );

        // Trace port and saturation counter
        sf_trace #(
                .trace_aw (trace_aw),
                .sat_w    (sat_w)
        ) u_trace (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .ce_i           (ce_i),
                .upd_i          (upd),
                .result_i       (result_o),
                .integ_i        (integ),
                .meas_i         (meas_q),
                .sat_hit_i      (sat_hit),
                .trace_o        (trace_o),
                .trace_addr_o   (trace_addr_o),
                .trace_strobe_o (trace_strobe_o),
                .trace_done_o   (trace_done),
                .sat_count_o    (sat_count_o)
        );

endmodule

`default_nettype wire

// File: rtl/sf_trace.sv
// Six words per update starting the ce cycle after upd; strobe is qualified by ce; counter sticks at max
`timescale 1ns/10ps
`default_nettype none

module sf_trace #(
        parameter int trace_aw = 7,
        parameter int sat_w    = 7
) (
        input  wire                    clk,
        input  wire                    rst_n_i,
        input  wire                    ce_i,
        input  wire                    upd_i,
        input  wire sf_pkg::sf_out_t   result_i,
        input  wire sf_pkg::acc_t      integ_i,
        input  wire sf_pkg::sample_t   meas_i,
        input  wire                    sat_hit_i,
        output sf_pkg::sf_trace_t      trace_o,
        output logic [trace_aw-1:0]    trace_addr_o,
        output logic                   trace_strobe_o,
        output logic                   trace_done_o,
        output logic [sat_w-1:0]       sat_count_o
);
        import sf_pkg::*;

        localparam int NWORDS = 6;

        acc_t       sh_q [NWORDS-1];
        logic [2:0] left_q;
        logic       strobe_q;

        assign trace_strobe_o = strobe_q & ce_i;
        assign trace_done_o   = strobe_q && (left_q == '0);

        // ----------------------------------------------------------------------
        // Word serializer
        // ----------------------------------------------------------------------

        // Order is meas, a, b, c, d, integ
        always_ff @(posedge clk) begin
                if (ce_i) begin
                        if (upd_i) begin
                                trace_o.data <= acc_t'(meas_i);
                                sh_q[0]      <= acc_t'(result_i.a);
                                sh_q[1]      <= acc_t'(result_i.b);
                                sh_q[2]      <= acc_t'(result_i.c);
                                sh_q[3]      <= acc_t'(result_i.d);
                                sh_q[4]      <= integ_i;
                        end else begin
                                trace_o.data <= sh_q[0];
                                for (int i = 0; i < NWORDS - 2; i++)
                                        sh_q[i] <= sh_q[i+1];
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        left_q       <= '0;
                        strobe_q     <= 1'b0;
                        trace_addr_o <= '0;
                        sat_count_o  <= '0;
                end else if (ce_i) begin
                        // Address moves past each word once it has been strobed
                        if (strobe_q)
                                trace_addr_o <= trace_addr_o + 1'b1;
                        if (upd_i) begin
                                strobe_q <= 1'b1;
                                left_q   <= 3'(NWORDS - 1);
                        end else begin
                                strobe_q <= (left_q != '0);
                                if (left_q != '0)
                                        left_q <= left_q - 1'b1;
                        end
                        // Saturation events stick at max
                        if (upd_i && sat_hit_i && sat_count_o != '1)
                                sat_count_o <= sat_count_o + 1'b1;
                end
        end

        // ----------------------------------------------------------------------
        // Checks
        // ----------------------------------------------------------------------

        // A new update never lands on a burst still in flight
        a_no_overlap: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                ce_i && upd_i |-> !(strobe_q && left_q != '0)
        );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sf_tb simulation with Verilator from the project root
set -u

cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -Wno-fatal \
        -f list.f --top-module sf_tb --Mdir obj_dir -o sf_sim; then
        echo "Verilator build failed"
        exit 1
fi

out=$(./obj_dir/sf_sim 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -qx "RESULT: PASS" <<< "$out"; then
        exit 0
fi
exit 1

// File: tb/sf_tb.sv
// Testbench for sf_top; coefficients are written only while idle and seed 32'hc11ffc4c fixes every run
`timescale 1ns/10ps
`default_nettype none

module sf_tb;
        import sf_pkg::*;

        localparam int      TRACE_AW = 7;
        localparam int      SAT_W    = 7;
        localparam int      SAT_MAX  = 2**SAT_W - 1;
        localparam int      CLK_P    = 4;
        localparam int      DRV      = 1;
        localparam int      N_RAND   = 20;
        localparam int      N_INTEG  = 30;
        localparam int      N_GAPS   = 120;
        localparam int      N_TRIG   = N_RAND + N_INTEG + N_GAPS;
        localparam int      LIMIT    = 40 * N_TRIG + 200;
        localparam longint  INTEG_MAX = (64'sd1 <<< (SF_TW - 1)) - 1;
        localparam bit [31:0] SEED   = 32'hc11ffc4c;

        // Expected outcome of one update with words in trace order
        typedef struct packed {
                sf_out_t          res;
                logic [SAT_W-1:0] sat_cnt;
                acc_t [5:0]       words;
        } exp_t;

        logic                clk;
        logic                rst_n_i;
        logic                ce_i;
        sample_t             meas_i;
        logic                trigger_i;
        logic                h_write_i;
        logic [SF_CAW-1:0]   h_addr_i;
        sample_t             h_data_i;
        sf_out_t             result_o;
        logic                busy_o;
        sf_trace_t           trace_o;
        logic [TRACE_AW-1:0] trace_addr_o;
        logic                trace_strobe_o;
        logic [SAT_W-1:0]    sat_count_o;

        longint              coef [4];
        longint              model_integ = 0;
        int                  model_sat   = 0;
        int                  model_hits  = 0;
        exp_t                exp_q [$];
        exp_t                cur;
        int                  widx   = 0;
        int                  bursts = 0;
        int                  cycles = 0;
        logic [TRACE_AW-1:0] exp_addr = '0;
        logic                gaps_on  = 1'b0;

        sf_top #(
                .trace_aw (TRACE_AW),
                .sat_w    (SAT_W)
        ) UUT (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .ce_i           (ce_i),
                .meas_i         (meas_i),
                .trigger_i      (trigger_i),
                .h_write_i      (h_write_i),
                .h_addr_i       (h_addr_i),
                .h_data_i       (h_data_i),
                .result_o       (result_o),
                .busy_o         (busy_o),
                .trace_o        (trace_o),
                .trace_addr_o   (trace_addr_o),
                .trace_strobe_o (trace_strobe_o),
                .sat_count_o    (sat_count_o)
        );

        initial clk = 1'b0;
        always #(CLK_P / 2) clk = ~clk;

        // Random clock enable gaps in the last phase only
        always @(posedge clk) begin
                #DRV;
                ce_i = gaps_on ? (($urandom % 4) != 0) : 1'b1;
        end

        // ----------------------------------------------------------------------
        // Reference model
        // ----------------------------------------------------------------------

        function automatic longint floor_prod(input longint x, input longint k);
                return (x * k) >>> SF_FRAC;
        endfunction

        function automatic longint clamp(input longint v, input int w);
                longint hi;
                longint lo;
                hi = (64'sd1 <<< (w - 1)) - 1;
                lo = -hi - 1;
                if (v > hi)
                        return hi;
                if (v < lo)
                        return lo;
                return v;
        endfunction

        // Advances the model integrator and saturation count
        function automatic exp_t model_update(input sample_t meas);
                longint m, a_raw, a, i_raw, i_new, b, c_raw, c, d_raw, d;
                logic   hit;
                exp_t   e;
                m     = meas;
                a_raw = floor_prod(m, coef[0]);
                a     = clamp(a_raw, SF_PW);
                i_raw = model_integ + floor_prod(m, coef[1]);
                i_new = clamp(i_raw, SF_TW);
                b     = clamp(i_new, SF_PW);
                c_raw = a + b;
                c     = clamp(c_raw, SF_PW);
                d_raw = floor_prod(c, coef[2]) + coef[3];
                d     = clamp(d_raw, SF_PW);
                hit   = (a != a_raw) || (i_new != i_raw) || (b != i_new)
                        || (c != c_raw) || (d != d_raw);
                model_integ = i_new;
                if (hit) begin
                        model_hits++;
                        if (model_sat < SAT_MAX)
                                model_sat++;
                end
                e.res      = '{a[SF_PW-1:0], b[SF_PW-1:0], c[SF_PW-1:0], d[SF_PW-1:0]};
                e.sat_cnt  = SAT_W'(model_sat);
                e.words[0] = m[SF_TW-1:0];
                e.words[1] = a[SF_TW-1:0];
                e.words[2] = b[SF_TW-1:0];
                e.words[3] = c[SF_TW-1:0];
                e.words[4] = d[SF_TW-1:0];
                e.words[5] = i_new[SF_TW-1:0];
                return e;
        endfunction

        // ----------------------------------------------------------------------
        // Checking
        // ----------------------------------------------------------------------

        task automatic check_val(input string name, input logic [71:0] exp_v,
                                 input logic [71:0] act_v);
                if (exp_v !== act_v) begin
                        $display("Error at %0t ns: %s expected %0h, got %0h",
                                 $time, name, exp_v, act_v);
                        $display("RESULT: FAIL");
                        $fatal(1, "value mismatch");
                end
        endtask

        // Sampled on the falling edge away from input changes
        always @(negedge clk) begin
                if (rst_n_i && trace_strobe_o) begin
                        if (widx == 0) begin
                                if (exp_q.size() == 0) begin
                                        $display("Trace word strobed with no update pending");
                                        $display("RESULT: FAIL");
                                        $fatal(1, "unexpected trace");
                                end else begin
                                        cur = exp_q.pop_front();
                                        check_val("result_o", cur.res, result_o);
                                        check_val("sat_count_o", cur.sat_cnt, sat_count_o);
                                end
                        end
                        // Busy covers the whole burst
                        check_val("busy_o", 1'b1, busy_o);
                        check_val("trace_o", cur.words[widx], trace_o.data);
                        check_val("trace_addr_o", exp_addr, trace_addr_o);
                        exp_addr = exp_addr + 1'b1;
                        if (widx == 5) begin
                                widx = 0;
                                bursts++;
                        end else begin
                                widx++;
                        end
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > LIMIT) begin
                        $display("Timeout after %0d cycles, %0d of %0d updates traced",
                                 cycles, bursts, N_TRIG);
                        $display("RESULT: FAIL");
                        $fatal(1, "timeout");
                end
        end

        // ----------------------------------------------------------------------
        // Stimulus
        // ----------------------------------------------------------------------

        task automatic wait_idle();
                @(negedge clk);
                while (busy_o)
                        @(negedge clk);
        endtask

        // Holds the write until a cycle with ce high takes it
        task automatic write_coef(input int idx, input sample_t val);
                @(posedge clk);
                #DRV;
                h_write_i = 1'b1;
                h_addr_i  = SF_CAW'(idx);
                h_data_i  = val;
                @(negedge clk);
                while (!ce_i)
                        @(negedge clk);
                @(posedge clk);
                #DRV;
                h_write_i = 1'b0;
                coef[idx] = val;
        endtask

        task automatic load_coefs(input sample_t kp, input sample_t ki,
                                  input sample_t kg, input sample_t kofs);
                wait_idle();
                write_coef(0, kp);
                write_coef(1, ki);
                write_coef(2, kg);
                write_coef(3, kofs);
        endtask

        // One accepted trigger and an optional pulse while busy
        task automatic run_update(input sample_t meas, input bit pulse_busy);
                wait_idle();
                @(posedge clk);
                #DRV;
                meas_i    = meas;
                trigger_i = 1'b1;
                @(negedge clk);
                while (!ce_i)
                        @(negedge clk);
                @(posedge clk);
                #DRV;
                trigger_i = 1'b0;
                exp_q.push_back(model_update(meas));
                if (pulse_busy) begin
                        @(posedge clk);
                        #DRV;
                        meas_i    = sample_t'($urandom);
                        trigger_i = 1'b1;
                        @(posedge clk);
                        #DRV;
                        trigger_i = 1'b0;
                end
        endtask

        initial begin
                void'($urandom(SEED));
                rst_n_i   = 1'b0;
                ce_i      = 1'b1;
                meas_i    = '0;
                trigger_i = 1'b0;
                h_write_i = 1'b0;
                h_addr_i  = '0;
                h_data_i  = '0;
                repeat (10) @(posedge clk);
                #DRV;
                rst_n_i = 1'b1;

                @(negedge clk);
                check_val("result_o", '0, result_o);
                check_val("sat_count_o", '0, sat_count_o);
                check_val("trace_addr_o", '0, trace_addr_o);
                check_val("busy_o", 1'b0, busy_o);
                check_val("trace_strobe_o", 1'b0, trace_strobe_o);

                // Random coefficients and samples with ce held high
                for (int n = 0; n < N_RAND; n++) begin
                        if (n % 5 == 0)
                                load_coefs(sample_t'($urandom), sample_t'($urandom),
                                           sample_t'($urandom), sample_t'($urandom));
                        run_update(sample_t'($urandom), 1'b0);
                end

                // Near unity K_I with large samples drives the integrator into its clamp
                load_coefs(sample_t'($urandom), 18'sd131071,
                           sample_t'($urandom), sample_t'($urandom));
                for (int n = 0; n < N_INTEG; n++)
                        run_update(sample_t'(131071 - ($urandom % 1024)), 1'b0);
                if (model_integ != INTEG_MAX) begin
                        $display("Integrator did not reach its upper clamp");
                        $display("RESULT: FAIL");
                        $fatal(1, "stimulus");
                end

                // Enable gaps and ignored triggers while the integrator stays pinned
                gaps_on = 1'b1;
                for (int n = 0; n < N_GAPS; n++)
                        run_update(sample_t'($urandom % 131072), 1'b1);

                while (bursts < N_TRIG)
                        @(negedge clk);
                wait_idle();
                if (model_hits <= SAT_MAX) begin
                        $display("Too few saturating updates to reach the counter limit");
                        $display("RESULT: FAIL");
                        $fatal(1, "stimulus");
                end
                check_val("sat_count_o", SAT_MAX, sat_count_o);
                $display("RESULT: PASS");
                $finish;
        end

endmodule

`default_nettype wire
